// ==== project.f ====
+incdir+common
+incdir+tb
common/fir_data_pkg.sv
common/fir_ctrl_pkg.sv
hw/tap_store.sv
hw/sample_ring.sv
hw/mac/mac_sequencer.sv
hw/mac/mac_accumulate.sv
hw/mac/result_round.sv
hw/dec_fir.sv
tb/dec_fir_tb.sv

// ==== tb/fir_ref_model.svh ====
`ifndef FIR_REF_MODEL_SVH
`define FIR_REF_MODEL_SVH

////////////////////////////////////////
// Reference model of one filter output
////////////////////////////////////////

// Tap table as the DUT should hold it after the last tap write
int model_taps [`DEC_NCOEFFS];

// Every sample sent since the last reset, oldest first
int sample_hist [$];

// Sum of products over the window that ends with the newest sample
// Tap k meets the k-th oldest of the last DEC_NCOEFFS samples
function automatic longint window_sum();
	longint sum;
	longint t;
	longint s;
	int base;
	int k;
	sum = 0;
	base = sample_hist.size() - `DEC_NCOEFFS;
	for (k = 0; k < `DEC_NCOEFFS; k++)
	begin
		t = model_taps[k];
		s = sample_hist[base + k];
		sum = sum + t * s;
	end
	return sum;
endfunction

// Scale by 2**DEC_SHIFT, drop the low bits with ties to even, then clamp
function automatic longint round_result(input longint acc);
	longint one;
	longint top;
	longint otop;
	longint scaled;
	longint kept;
	longint frac;
	longint half;
	int drop;
	one = 1;
	top = one << (`DEC_AW - 1);
	otop = one << (`DEC_OW - 1);
	drop = `DEC_AW - `DEC_OW;
	half = one << (drop - 1);
	scaled = acc << `DEC_SHIFT;
	// The scaled sum has to fit the accumulator width, or the output clamps
	if (scaled > top - 1)
		return otop - 1;
	if (scaled < -top)
		return -otop;
	kept = scaled >>> drop;
	frac = scaled - (kept << drop);
	if (frac > half || (frac == half && kept[0]))
		kept = kept + 1;
	// Rounding up can still push a positive value past the top
	if (kept > otop - 1)
		return otop - 1;
	return kept;
endfunction

`endif

// ==== tb/dec_fir_tb.sv ====
`timescale 1ns/1ns
`include "dec_fir_defines.svh"

module dec_fir_tb;

	localparam int RESET_CYCLES = 8;
	localparam int OUT_TIMEOUT  = 100;
	localparam int OUT_LATENCY  = 3;
	localparam int SAMPLE_GAP   = 5;
	localparam int NUM_ROWS     = 6;
	localparam logic [31:0] LFSR_SEED = 32'hf19aac56;

	// Tap patterns
	localparam logic [3:0] TAP_RAMP   = 4'd0;
	localparam logic [3:0] TAP_RANDOM = 4'd1;
	localparam logic [3:0] TAP_MAX    = 4'd2;
	localparam logic [3:0] TAP_ONE    = 4'd3;
	localparam logic [3:0] TAP_WRAP   = 4'd4;

	// Sample patterns
	localparam logic [3:0] SMP_RANDOM  = 4'd0;
	localparam logic [3:0] SMP_IMPULSE = 4'd1;
	localparam logic [3:0] SMP_FULL    = 4'd2;
	localparam logic [3:0] SMP_TIE     = 4'd3;

	// One row of the stimulus table
	// The test name lives in its own array
	typedef struct packed {
		logic [3:0] tap_pat;
		logic [3:0] smp_pat;
		logic [7:0] groups;
		logic [7:0] tap_writes;
	} test_row_t;

	logic                  i_clk = 1'b0;
	logic                  i_reset;
	logic                  i_tap_wr;
	fir_data_pkg::coeff_t  i_tap;
	logic                  i_ce;
	fir_data_pkg::sample_t i_sample;
	logic                  o_ce;
	fir_data_pkg::result_t o_result;

	test_row_t rows [NUM_ROWS];
	string     row_names [NUM_ROWS];
	int        n_rows = 0;

	logic [31:0] lfsr_state;
	int error_count;
	int check_count;
	int smp_count;
	int trig_count;
	int ce_base;
	int ce_count = 0;
	bit timed_out;

	// Expected outputs, one per trigger, and whether each one is known
	longint expect_q [$];
	bit     expect_chk [$];

	`include "fir_ref_model.svh"

	dec_fir dec_fir_i (
		.i_clk    (i_clk),
		.i_reset  (i_reset),
		.i_tap_wr (i_tap_wr),
		.i_tap    (i_tap),
		.i_ce     (i_ce),
		.i_sample (i_sample),
		.o_ce     (o_ce),
		.o_result (o_result)
	);

	always #5 i_clk = ~i_clk;

	// Every output strobe outside reset, so extra strobes show up in the count
	always @(posedge i_clk)
	begin
		if (!i_reset && o_ce === 1'b1)
			ce_count <= ce_count + 1;
	end

	////////////////////////////////////////
	// Random numbers
	////////////////////////////////////////

	// Fibonacci LFSR on x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// One step per bit taken
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		int b;
		v = '0;
		for (b = 0; b < n; b++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	////////////////////////////////////////
	// Stimulus patterns
	////////////////////////////////////////

	function automatic int tap_for(input logic [3:0] pat, input int w);
		logic [31:0] bits;
		logic signed [`DEC_CW-1:0] c;
		int v;
		v = 0;
		case (pat)
		TAP_RAMP:
			v = w * 137 - 900;
		TAP_RANDOM:
		begin
			bits = random_bits(`DEC_CW);
			c = bits[`DEC_CW-1:0];
			v = c;
		end
		TAP_MAX:
			v = (1 << (`DEC_CW - 1)) - 1;
		TAP_ONE:
			v = (w == 0) ? 1 : 0;
		TAP_WRAP:
			// Writes past the last tap land on taps 0 to 3 again
			v = (w < `DEC_NCOEFFS) ? w * 137 - 900 : -1500 - (w - `DEC_NCOEFFS) * 111;
		default:
			v = 0;
		endcase
		return v;
	endfunction

	function automatic int sample_for(input logic [3:0] pat, input int g, input int j);
		logic [31:0] bits;
		logic signed [`DEC_IW-1:0] s;
		int v;
		v = 0;
		case (pat)
		SMP_RANDOM:
		begin
			bits = random_bits(`DEC_IW);
			s = bits[`DEC_IW-1:0];
			v = s;
		end
		// Four impulses at every position in a group, so all taps come out
		// An amplitude of 64 maps one tap to one output LSB
		SMP_IMPULSE:
			v = ((g % 5 == 0) && (j == (g / 5) % `DEC_NDOWN)) ? 64 : 0;
		SMP_FULL:
			v = (g < 4) ? 32767 : -32768;
		// Each value sits exactly halfway between two outputs
		SMP_TIE:
			case (g % 8)
			0: v = 32;
			1: v = 96;
			2: v = 160;
			3: v = 32736;
			4: v = -32;
			5: v = -96;
			6: v = -160;
			default: v = -32736;
			endcase
		default:
			v = 0;
		endcase
		return v;
	endfunction

	task automatic add_row(input string name, input logic [3:0] tap_pat,
		input logic [3:0] smp_pat, input int groups, input int tap_writes);
		test_row_t r;
		r.tap_pat = tap_pat;
		r.smp_pat = smp_pat;
		r.groups = groups[7:0];
		r.tap_writes = tap_writes[7:0];
		rows[n_rows] = r;
		row_names[n_rows] = name;
		n_rows++;
	endtask

	////////////////////////////////////////
	// Driving and checking
	////////////////////////////////////////

	task automatic check_value(input string name, input logic signed [63:0] expected,
		input logic signed [63:0] actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("mismatch %s expected %0d actual %0d", name, expected, actual);
		end
	endtask

	task automatic apply_reset(input string name);
		int c;
		@(posedge i_clk);
		i_reset  <= 1'b1;
		i_ce     <= 1'b0;
		i_tap_wr <= 1'b0;
		for (c = 0; c < RESET_CYCLES; c++)
		begin
			@(posedge i_clk);
			// From the second reset edge on the strobe has been cleared
			if (c > 0)
				check_value(name, 0, o_ce);
		end
		i_reset <= 1'b0;
	endtask

	task automatic write_taps(input logic [3:0] pat, input int writes);
		int w;
		int v;
		for (w = 0; w < writes; w++)
		begin
			v = tap_for(pat, w);
			@(posedge i_clk);
			i_tap_wr <= 1'b1;
			i_tap    <= v[`DEC_CW-1:0];
			model_taps[w % `DEC_NCOEFFS] = v;
		end
		@(posedge i_clk);
		i_tap_wr <= 1'b0;
	endtask

	// Waits for the strobe that follows a trigger and checks its value
	task automatic wait_output(input string name, inout int cycles);
		int waited;
		bit got;
		logic signed [63:0] act;
		logic signed [63:0] exp_v;
		bit exp_known;
		waited = 0;
		got = 1'b0;
		while (!got && waited < OUT_TIMEOUT)
		begin
			@(posedge i_clk);
			waited++;
			if (o_ce === 1'b1)
				got = 1'b1;
		end
		cycles = cycles + waited;
		if (!got)
		begin
			$display("timeout in %s: no o_ce within %0d cycles after sample %0d",
				name, OUT_TIMEOUT, smp_count);
			timed_out = 1'b1;
		end
		else
		begin
			// The strobe comes a fixed number of cycles after the trigger
			check_value(name, OUT_LATENCY, waited);
			// The front entry is the walk before the one just started
			exp_v = expect_q.pop_front();
			exp_known = expect_chk.pop_front();
			act = {{(64-`DEC_OW){o_result[`DEC_OW-1]}}, o_result};
			if (exp_known)
				check_value(name, exp_v, act);
		end
	endtask

	task automatic send_sample(input string name, input int value, input bit chk);
		bit trig;
		bit first_trig;
		int cycles;
		if (!timed_out)
		begin
			trig = (smp_count % `DEC_NDOWN) == 0;
			first_trig = (smp_count == 0);
			@(posedge i_clk);
			i_ce     <= 1'b1;
			i_sample <= value[`DEC_IW-1:0];
			@(posedge i_clk);
			i_ce <= 1'b0;
			cycles = 1;
			sample_hist.push_back(value);
			smp_count++;
			if (trig)
			begin
				trig_count++;
				// Windows that reach back before the warm-up hold unknown data
				if (sample_hist.size() >= `DEC_NCOEFFS)
				begin
					expect_q.push_back(round_result(window_sum()));
					expect_chk.push_back(chk);
				end
				else
				begin
					expect_q.push_back(0);
					expect_chk.push_back(1'b0);
				end
				// No sum is finished yet at the first trigger after reset
				if (!first_trig)
					wait_output(name, cycles);
			end
			while (!timed_out && cycles < SAMPLE_GAP - 1)
			begin
				@(posedge i_clk);
				cycles++;
			end
		end
	endtask

	task automatic run_test(input int r);
		test_row_t row;
		string name;
		int errs_before;
		int checks_before;
		int g;
		int j;
		int k;
		row = rows[r];
		name = row_names[r];
		errs_before = error_count;
		checks_before = check_count;
		apply_reset(name);
		sample_hist.delete();
		expect_q.delete();
		expect_chk.delete();
		smp_count = 0;
		trig_count = 0;
		write_taps(row.tap_pat, row.tap_writes);
		ce_base = ce_count;
		// Zeros refill the sample ring, which keeps its contents over reset
		for (k = 0; k < `DEC_NCOEFFS; k++)
		begin
			send_sample(name, 0, 1'b0);
			if (k == `DEC_NDOWN - 1 && !timed_out)
				check_value(name, 0, ce_count - ce_base);
		end
		for (g = 0; g < row.groups; g++)
		begin
			for (j = 0; j < `DEC_NDOWN; j++)
				send_sample(name, sample_for(row.smp_pat, g, j), 1'b1);
		end
		// One more trigger brings out the sum of the last group
		send_sample(name, 0, 1'b0);
		if (!timed_out)
		begin
			repeat (SAMPLE_GAP) @(posedge i_clk);
			// Every trigger but the first one gives exactly one strobe
			check_value(name, trig_count - 1, ce_count - ce_base);
		end
		$display("%s: %0d checks, %0d errors", name, check_count - checks_before,
			error_count - errs_before);
	endtask

	initial
	begin
		int r;
		i_reset = 1'b1;
		i_tap_wr = 1'b0;
		i_tap = '0;
		i_ce = 1'b0;
		i_sample = '0;
		lfsr_state = LFSR_SEED;
		error_count = 0;
		check_count = 0;
		smp_count = 0;
		trig_count = 0;
		ce_base = 0;
		timed_out = 1'b0;
		add_row("reset_first", TAP_RAMP, SMP_RANDOM, 2, 16);
		add_row("impulse", TAP_RAMP, SMP_IMPULSE, 20, 16);
		add_row("random", TAP_RANDOM, SMP_RANDOM, 8, 16);
		add_row("saturate", TAP_MAX, SMP_FULL, 8, 16);
		add_row("round_even", TAP_ONE, SMP_TIE, 12, 16);
		add_row("tap_wrap", TAP_WRAP, SMP_IMPULSE, 20, 20);
		for (r = 0; r < n_rows; r++)
		begin
			if (!timed_out)
				run_test(r);
		end
		$display("%0d tests, %0d checks, %0d errors", n_rows, check_count, error_count);
		if (error_count == 0 && !timed_out)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== hw/dec_fir.sv ====
`timescale 1ns/1ns

// Decimating FIR filter with one multiplier shared over all taps
// Samples come in on i_ce strobes, one output leaves on o_ce per group
module dec_fir
(
	input  logic                    i_clk,
	input  logic                    i_reset,
	input  logic                    i_tap_wr,
	input  fir_data_pkg::coeff_t    i_tap,
	input  logic                    i_ce,
	input  fir_data_pkg::sample_t   i_sample,
	output logic                    o_ce,
	output fir_data_pkg::result_t   o_result
);

	// Sample write pointer, used to find the oldest sample of a window
	fir_data_pkg::tap_idx_t  wr_idx;

	// Read addresses from the sequencer to both memories
	fir_ctrl_pkg::rd_addr_t  rd;

	// Memory read data, valid one cycle after the address
	fir_data_pkg::sample_t   rd_sample;
	fir_data_pkg::coeff_t    rd_tap;

	// Pipeline flags lined up with the product register
	fir_ctrl_pkg::mac_ctrl_t ctrl;

	// Finished sum and its strobe
	fir_data_pkg::acc_t      acc;
	logic                    sum_done;

	////////////////////////////////////////
	// Storage
	////////////////////////////////////////

	tap_store tap_store_i (
		.i_clk    (i_clk),
		.i_reset  (i_reset),
		.i_tap_wr (i_tap_wr),
		.i_tap    (i_tap),
		.i_rd_idx (rd.tap_idx),
		.o_tap    (rd_tap)
	);

	sample_ring sample_ring_i (
		.i_clk    (i_clk),
		.i_ce     (i_ce),
		.i_sample (i_sample),
		.i_rd_idx (rd.data_idx),
		.o_wr_idx (wr_idx),
		.o_sample (rd_sample)
	);

	////////////////////////////////////////
	// Multiply and accumulate
	////////////////////////////////////////

	mac_sequencer mac_sequencer_i (
		.i_clk    (i_clk),
		.i_reset  (i_reset),
		.i_ce     (i_ce),
		.i_wr_idx (wr_idx),
		.o_rd     (rd),
		.o_ctrl   (ctrl)
	);

	mac_accumulate mac_accumulate_i (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_sample   (rd_sample),
		.i_tap      (rd_tap),
		.i_ctrl     (ctrl),
		.o_acc      (acc),
		.o_sum_done (sum_done)
	);

	result_round result_round_i (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_acc      (acc),
		.i_sum_done (sum_done),
		.o_ce       (o_ce),
		.o_result   (o_result)
	);

endmodule

// ==== hw/mac/result_round.sv ====
`timescale 1ns/1ns
`include "dec_fir_defines.svh"

// Scales the finished sum, rounds it to the output width and saturates
module result_round
(
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  fir_data_pkg::acc_t    i_acc,
	input  logic                  i_sum_done,
	output logic                  o_ce,
	output fir_data_pkg::result_t o_result
);

	// Number of low bits dropped by the rounding step
	localparam int RW = `DEC_AW - `DEC_OW;

	localparam fir_data_pkg::result_t RES_MAX = {1'b0, {(`DEC_OW-1){1'b1}}};
	localparam fir_data_pkg::result_t RES_MIN = {1'b1, {(`DEC_OW-1){1'b0}}};

	logic [`DEC_SHIFT:0] top_bits;
	fir_data_pkg::acc_t  scaled;
	fir_data_pkg::acc_t  rounded;
	logic                sgn;
	logic                scale_ovf;
	logic                round_ovf;

	// The shift overflows unless the bits shifted out all match the sign
	assign sgn       = i_acc[`DEC_AW-1];
	assign top_bits  = i_acc[`DEC_AW-1:`DEC_AW-`DEC_SHIFT-1];
	assign scale_ovf = !((&top_bits) || !(|top_bits));
	assign scaled    = {i_acc[`DEC_AW-`DEC_SHIFT-1:0], {`DEC_SHIFT{1'b0}}};

	// Ties to even: add just under one half, plus the kept LSB
	// An exact half then carries only when the kept value is odd
	assign rounded = scaled + {{`DEC_OW{1'b0}}, scaled[RW], {(RW-1){!scaled[RW]}}};

	// Only a positive value can cross the top of the range by rounding up
	assign round_ovf = !sgn && rounded[`DEC_AW-1];

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_ce <= 1'b0;
		else
			o_ce <= i_sum_done;
	end

	// Held steady between strobes
	always_ff @(posedge i_clk)
	begin
		if (i_sum_done)
		begin
			if (scale_ovf || round_ovf)
				o_result <= sgn ? RES_MIN : RES_MAX;
			else
				o_result <= rounded[`DEC_AW-1:RW];
		end
	end

endmodule

// ==== hw/mac/mac_accumulate.sv ====
`timescale 1ns/1ns
`include "dec_fir_defines.svh"

// Registered multiplier followed by the accumulator of one tap walk
module mac_accumulate
(
	input  logic                    i_clk,
	input  logic                    i_reset,
	input  fir_data_pkg::sample_t   i_sample,
	input  fir_data_pkg::coeff_t    i_tap,
	input  fir_ctrl_pkg::mac_ctrl_t i_ctrl,
	output fir_data_pkg::acc_t      o_acc,
	output logic                    o_sum_done
);

	// Product width, and the guard bits added when it joins the sum
	localparam int PW = `DEC_IW + `DEC_CW;
	localparam int GW = `DEC_AW - PW;

	fir_data_pkg::product_t product;
	fir_data_pkg::acc_t     product_ext;
	fir_data_pkg::acc_t     acc;

	// Signed times signed, one cycle latency
	always_ff @(posedge i_clk)
	begin
		product <= i_sample * i_tap;
	end

	// Sign extend so negative products subtract from the sum
	assign product_ext = {{GW{product[PW-1]}}, product};

	////////////////////////////////////////
	// Accumulator
	////////////////////////////////////////

	// The first product of a walk replaces the old sum
	// The others are added on top of it
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			acc <= '0;
		else if (i_ctrl.first)
			acc <= product_ext;
		else if (i_ctrl.run)
			acc <= acc + product_ext;
	end

	// When a new walk reaches the accumulator the last one is complete
	// Up to that point the accumulator still holds the finished sum
	assign o_sum_done = i_ctrl.first && i_ctrl.sum_ok;

	assign o_acc = acc;

endmodule

// ==== hw/mac/mac_sequencer.sv ====
`timescale 1ns/1ns
`include "dec_fir_defines.svh"

// Finds the trigger sample of each group and walks all taps once
// Tap 0 is addressed in the trigger cycle itself, the rest follow one per clock
module mac_sequencer
(
	input  logic                    i_clk,
	input  logic                    i_reset,
	input  logic                    i_ce,
	input  fir_data_pkg::tap_idx_t  i_wr_idx,
	output fir_ctrl_pkg::rd_addr_t  o_rd,
	output fir_ctrl_pkg::mac_ctrl_t o_ctrl
);

	localparam fir_data_pkg::down_cnt_t DOWN_LOAD =
		fir_data_pkg::down_cnt_t'(`DEC_NDOWN - 1);
	localparam fir_data_pkg::tap_idx_t TAP_LAST =
		fir_data_pkg::tap_idx_t'(`DEC_NCOEFFS - 1);
	localparam fir_data_pkg::tap_idx_t STEP_ONE = fir_data_pkg::tap_idx_t'(1);
	localparam fir_data_pkg::tap_idx_t STEP_TWO = fir_data_pkg::tap_idx_t'(2);

	fir_ctrl_pkg::seq_state_t state;
	fir_data_pkg::down_cnt_t  countdown;
	fir_data_pkg::tap_idx_t   tap_idx;
	fir_data_pkg::tap_idx_t   data_idx;
	fir_data_pkg::tap_idx_t   oldest_idx;
	logic                     trigger;
	logic                     walking;
	logic                     last_tap;

	// Markers one stage (memory read) and two stages (product) behind
	logic                     d_first, d_run, d_last;
	logic                     p_first, p_run, p_last;
	logic                     sum_ok;

	////////////////////////////////////////
	// Decimation countdown
	////////////////////////////////////////

	// A sample that arrives with the count at zero opens a new group
	assign trigger = i_ce && (countdown == '0);

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			countdown <= '0;
		else if (i_ce)
		begin
			if (countdown == '0)
				countdown <= DOWN_LOAD;
			else
				countdown <= countdown - 1'b1;
		end
	end

	////////////////////////////////////////
	// Tap walk
	////////////////////////////////////////

	assign walking  = (state == fir_ctrl_pkg::SEQ_WALK);
	assign last_tap = walking && (tap_idx == TAP_LAST);

	// The entry just past the writer holds the oldest sample of the window
	// An incoming sample moves the writer on by one before the next cycle
	assign oldest_idx = i_wr_idx + (i_ce ? STEP_TWO : STEP_ONE);

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			state    <= fir_ctrl_pkg::SEQ_IDLE;
			tap_idx  <= '0;
			data_idx <= i_wr_idx + STEP_ONE;
		end
		else
		begin
			case (state)
			fir_ctrl_pkg::SEQ_IDLE:
			begin
				// While idle the addresses already point at tap 0 and the oldest sample
				if (trigger)
				begin
					state    <= fir_ctrl_pkg::SEQ_WALK;
					tap_idx  <= STEP_ONE;
					data_idx <= data_idx + STEP_ONE;
				end
				else
					data_idx <= oldest_idx;
			end
			fir_ctrl_pkg::SEQ_WALK:
			begin
				if (last_tap)
				begin
					state    <= fir_ctrl_pkg::SEQ_IDLE;
					tap_idx  <= '0;
					data_idx <= oldest_idx;
				end
				else
				begin
					tap_idx  <= tap_idx + STEP_ONE;
					data_idx <= data_idx + STEP_ONE;
				end
			end
			default:
				state <= fir_ctrl_pkg::SEQ_IDLE;
			endcase
		end
	end

	assign o_rd = '{data_idx: data_idx, tap_idx: tap_idx};

	////////////////////////////////////////
	// Pipeline markers
	////////////////////////////////////////

	// Markers follow the read and the multiply so they meet each product
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			d_first <= 1'b0;
			d_run   <= 1'b0;
			d_last  <= 1'b0;
			p_first <= 1'b0;
			p_run   <= 1'b0;
			p_last  <= 1'b0;
			sum_ok  <= 1'b0;
		end
		else
		begin
			d_first <= trigger && !walking;
			d_run   <= walking;
			d_last  <= last_tap;
			p_first <= d_first;
			p_run   <= d_run;
			p_last  <= d_last;
			// The last product has just been added, so one full sum now exists
			if (p_last)
				sum_ok <= 1'b1;
		end
	end

	assign o_ctrl = '{first: p_first, run: p_run, sum_ok: sum_ok};

endmodule

// ==== hw/sample_ring.sv ====
`timescale 1ns/1ns
`include "dec_fir_defines.svh"

// Circular buffer holding the most recent DEC_NCOEFFS samples
module sample_ring
(
	input  logic                   i_clk,
	input  logic                   i_ce,
	input  fir_data_pkg::sample_t  i_sample,
	input  fir_data_pkg::tap_idx_t i_rd_idx,
	output fir_data_pkg::tap_idx_t o_wr_idx,
	output fir_data_pkg::sample_t  o_sample
);

	localparam fir_data_pkg::tap_idx_t LAST_IDX =
		fir_data_pkg::tap_idx_t'(`DEC_NCOEFFS - 1);

	fir_data_pkg::sample_t  mem [`DEC_NCOEFFS];

	// Only the distance between reader and writer matters
	// so the pointer starts from its power-up value
	fir_data_pkg::tap_idx_t wr_idx = '0;

	// Every accepted sample overwrites the oldest entry
	always_ff @(posedge i_clk)
	begin
		if (i_ce)
		begin
			mem[wr_idx] <= i_sample;
			if (wr_idx == LAST_IDX)
				wr_idx <= '0;
			else
				wr_idx <= wr_idx + 1'b1;
		end
	end

	// A read of the slot being written returns the old sample
	always_ff @(posedge i_clk)
	begin
		o_sample <= mem[i_rd_idx];
	end

	assign o_wr_idx = wr_idx;

endmodule

// ==== hw/tap_store.sv ====
`timescale 1ns/1ns
`include "dec_fir_defines.svh"

// Run-time loadable tap memory
// Taps are written in order, one per i_tap_wr strobe
module tap_store
(
	input  logic                   i_clk,
	input  logic                   i_reset,
	input  logic                   i_tap_wr,
	input  fir_data_pkg::coeff_t   i_tap,
	input  fir_data_pkg::tap_idx_t i_rd_idx,
	output fir_data_pkg::coeff_t   o_tap
);

	// Index of the final tap, where the write pointer turns around
	localparam fir_data_pkg::tap_idx_t LAST_IDX =
		fir_data_pkg::tap_idx_t'(`DEC_NCOEFFS - 1);

	fir_data_pkg::coeff_t   mem [`DEC_NCOEFFS];
	fir_data_pkg::tap_idx_t wr_ptr;

	// Reset brings the pointer back to tap 0 so a fresh table can be loaded
	// Writing past the last tap starts over at tap 0
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			wr_ptr <= '0;
		else if (i_tap_wr)
		begin
			if (wr_ptr == LAST_IDX)
				wr_ptr <= '0;
			else
				wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (i_tap_wr)
			mem[wr_ptr] <= i_tap;
	end

	// One cycle read latency, matching the sample ring
	always_ff @(posedge i_clk)
	begin
		o_tap <= mem[i_rd_idx];
	end

endmodule

// ==== common/fir_ctrl_pkg.sv ====
// Control types shared between the sequencer and the MAC block
package fir_ctrl_pkg;

	// The sequencer either waits for a trigger sample or walks the taps
	typedef enum logic {
		SEQ_IDLE,
		SEQ_WALK
	} seq_state_t;

	// Read addresses presented to both memories in the same cycle
	typedef struct packed {
		fir_data_pkg::tap_idx_t data_idx;
		fir_data_pkg::tap_idx_t tap_idx;
	} rd_addr_t;

	// Flags that travel alongside the product register
	// The first flag marks the product that opens a new sum
	// The run flag marks every later product of the same walk
	// The sum_ok flag says the accumulator has finished a sum since reset
	typedef struct packed {
		logic first;
		logic run;
		logic sum_ok;
	} mac_ctrl_t;

endpackage

// ==== common/fir_data_pkg.sv ====
`include "dec_fir_defines.svh"

// Vector types for the values that move through the filter data path
package fir_data_pkg;

	// Input samples are two's complement
	typedef logic signed [`DEC_IW-1:0] sample_t;

	// Taps are two's complement as well
	typedef logic signed [`DEC_CW-1:0] coeff_t;

	// Full precision product of one sample and one tap
	typedef logic signed [`DEC_IW+`DEC_CW-1:0] product_t;

	// Running sum over one tap walk
	// Sized so that all taps at full scale still fit
	typedef logic signed [`DEC_AW-1:0] acc_t;

	// Rounded and saturated filter output
	typedef logic signed [`DEC_OW-1:0] result_t;

	// Index into either the tap memory or the sample ring
	typedef logic [`DEC_LGNCOEFFS-1:0] tap_idx_t;

	// Counts the samples left until the next output
	typedef logic [`DEC_LGNDOWN-1:0] down_cnt_t;

endpackage

// ==== common/dec_fir_defines.svh ====
`ifndef DEC_FIR_DEFINES_SVH
`define DEC_FIR_DEFINES_SVH

////////////////////////////////////////
// Data path widths
////////////////////////////////////////

// Width of one incoming sample
`define DEC_IW 16

// Width of one filter tap
`define DEC_CW 12

// Width of the filtered output
`define DEC_OW 24

////////////////////////////////////////
// Filter geometry
////////////////////////////////////////

// Number of taps, and the bits needed to index them
`define DEC_NCOEFFS 16
`define DEC_LGNCOEFFS 4

// One output is produced for every DEC_NDOWN input samples
`define DEC_NDOWN 4
`define DEC_LGNDOWN 2

// Left shift applied to the sum before it is rounded
`define DEC_SHIFT 2

// The accumulator holds a full product plus one growth bit per tap index bit
`define DEC_AW (`DEC_IW + `DEC_CW + `DEC_LGNCOEFFS)

`endif
